// File: byte_rx_port.sv
`timescale 1ns/10ps

module byte_rx_port
    import comm_pkg::*;
(
    input  logic         in_clk,
    input  logic         in_rst,
    input  byte_t        rx_data,
    input  logic         rx_req,
    output logic         rx_ack,
    output logic         rx_enable,
    input  logic         ready,
    output byte_strobe_t rx_byte
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_ACK,
        R_REL
    } rx_state_t;

    rx_state_t state;
    logic      rx_valid;
    byte_t     rx_value;

    // Host may only start a byte while we sit idle and the decoder can take it
    assign rx_enable = (state == R_IDLE) && ready;

    ////////////////////
    // Handshake FSM

    always_ff @(posedge in_clk or posedge in_rst)
    begin
        if (in_rst)
        begin
            state    <= R_IDLE;
            rx_ack   <= 1'b0;
            rx_valid <= 1'b0;
        end
        else
        begin
            rx_valid <= 1'b0;
            case (state)
                R_IDLE:
                begin
                    if (rx_req && rx_enable)
                    begin
                        state  <= R_ACK;
                        rx_ack <= 1'b1;
                    end
                end
                R_ACK:
                begin
                    // Host let go of req, so the byte is complete
                    if (!rx_req)
                    begin
                        state    <= R_REL;
                        rx_ack   <= 1'b0;
                        rx_valid <= 1'b1;
                    end
                end
                R_REL:
                begin
                    // Gap cycle lets the decoder drop ready first
                    state <= R_IDLE;
                end
                default:
                begin
                    state <= R_IDLE;
                end
            endcase
        end
    end

    // Byte is captured on acceptance
    always_ff @(posedge in_clk)
    begin
        if (state == R_IDLE && rx_req && rx_enable)
            rx_value <= rx_data;
    end

    assign rx_byte = '{valid: rx_valid, value: rx_value};

    assert property (@(posedge in_clk) disable iff (in_rst) rx_valid |=> !rx_valid)
        else $error("rx_byte strobe lasted more than one cycle");

endmodule

// File: byte_tx_port.sv
`timescale 1ns/10ps

module byte_tx_port
    import comm_pkg::*;
(
    input  logic         in_clk,
    input  logic         in_rst,
    input  byte_strobe_t ans_byte,
    output byte_t        tx_data,
    output logic         tx_req,
    input  logic         tx_ack,
    output logic         tx_empty
);

    typedef enum logic [1:0] {
        T_LOAD,
        T_WAIT_HI,
        T_WAIT_LO
    } tx_state_t;

    tx_state_t state;

    byte_t                fifo_mem [ANS_FIFO_DEPTH];
    logic [ANS_PTR_W-1:0] wr_ptr;
    logic [ANS_PTR_W-1:0] rd_ptr;
    logic [ANS_PTR_W:0]   count;

    logic fifo_empty;
    logic fifo_full;
    logic push;
    logic pop;

    assign fifo_empty = (count == '0);
    assign fifo_full  = (count == (ANS_PTR_W + 1)'(ANS_FIFO_DEPTH));
    assign push       = ans_byte.valid;
    // Head leaves once the host has it
    assign pop        = (state == T_WAIT_HI) && tx_ack;

    ////////////////////
    // Answer FIFO

    always_ff @(posedge in_clk or posedge in_rst)
    begin
        if (in_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + ANS_PTR_W'(1);
            if (pop)
                rd_ptr <= rd_ptr + ANS_PTR_W'(1);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge in_clk)
    begin
        if (push)
            fifo_mem[wr_ptr] <= ans_byte.value;
    end

    ////////////////////
    // Transmit handshake

    always_ff @(posedge in_clk or posedge in_rst)
    begin
        if (in_rst)
            state <= T_LOAD;
        else
        begin
            case (state)
                T_LOAD:
                begin
                    if (!fifo_empty)
                        state <= T_WAIT_HI;
                end
                T_WAIT_HI:
                begin
                    if (tx_ack)
                        state <= T_WAIT_LO;
                end
                T_WAIT_LO:
                begin
                    // Byte done only once ack is back low
                    if (!tx_ack)
                        state <= T_LOAD;
                end
                default:
                begin
                    state <= T_LOAD;
                end
            endcase
        end
    end

    assign tx_data  = fifo_mem[rd_ptr];
    assign tx_req   = (state == T_WAIT_HI);
    assign tx_empty = fifo_empty && (state == T_LOAD);

    assert property (@(posedge in_clk) disable iff (in_rst) push |-> !fifo_full)
        else $error("answer pushed into a full FIFO");

    assert property (@(posedge in_clk) disable iff (in_rst)
                     tx_req |=> (!tx_req || $stable(tx_data)))
        else $error("tx_data changed during a request");

endmodule

// File: comm_link_top.sv
`timescale 1ns/10ps

module comm_link_top
    import comm_pkg::*;
(
    input  logic  in_clk,
    input  logic  in_rst,
    // Receive link from the host
    input  byte_t rx_data,
    input  logic  rx_req,
    output logic  rx_ack,
    output logic  rx_enable,
    // Transmit link to the host
    output byte_t tx_data,
    output logic  tx_req,
    input  logic  tx_ack
);

    byte_strobe_t rx_byte;
    byte_strobe_t ans_byte;
    logic         ready;
    logic         tx_empty;

    ////////////////////
    // Input side

    byte_rx_port i_rx (
        .in_clk    (in_clk),
        .in_rst    (in_rst),
        .rx_data   (rx_data),
        .rx_req    (rx_req),
        .rx_ack    (rx_ack),
        .rx_enable (rx_enable),
        .ready     (ready),
        .rx_byte   (rx_byte)
    );

    // Frame decode and register bank
    proto_decoder i_dec (
        .in_clk   (in_clk),
        .in_rst   (in_rst),
        .rx_byte  (rx_byte),
        .ready    (ready),
        .ans_byte (ans_byte),
        .tx_empty (tx_empty)
    );

    ////////////////////
    // Output side

    byte_tx_port i_tx (
        .in_clk   (in_clk),
        .in_rst   (in_rst),
        .ans_byte (ans_byte),
        .tx_data  (tx_data),
        .tx_req   (tx_req),
        .tx_ack   (tx_ack),
        .tx_empty (tx_empty)
    );

endmodule

// File: comm_pkg.sv
package comm_pkg;

    ////////////////////
    // Link byte and sizes

    typedef logic [7:0] byte_t;

    localparam int NUM_REGS       = 16;
    localparam int REG_ADDR_W     = 4;

    // Longest answer is a 4-byte burst read, so the FIFO never overflows
    localparam int ANS_FIFO_DEPTH = 4;
    localparam int ANS_PTR_W      = $clog2(ANS_FIFO_DEPTH);

    ////////////////////
    // Command codes

    localparam byte_t CMD_ECHO_CMD  = 8'hAA;
    localparam byte_t CMD_ECHO_DATA = 8'h55;

    // Opcodes live in the high nibble of the command byte
    localparam logic [3:0] OP_WRITE = 4'h1;
    localparam logic [3:0] OP_READ  = 4'h2;

    ////////////////////
    // Frame views

    // Raw view, command byte then data byte
    typedef struct packed {
        byte_t cmd;
        byte_t data;
    } frame_bytes_t;

    // Register view of the same 16 bits
    typedef struct packed {
        logic [3:0]            op;
        logic [REG_ADDR_W-1:0] addr;
        byte_t                 data;
    } frame_fields_t;

    typedef union packed {
        frame_bytes_t  bytes;
        frame_fields_t fields;
    } frame_u;

    // One-cycle byte strobe between blocks, no back-pressure
    typedef struct packed {
        logic  valid;
        byte_t value;
    } byte_strobe_t;

endpackage

// File: proto_decoder.sv
`timescale 1ns/10ps

module proto_decoder
    import comm_pkg::*;
(
    input  logic         in_clk,
    input  logic         in_rst,
    input  byte_strobe_t rx_byte,
    output logic         ready,
    output byte_strobe_t ans_byte,
    input  logic         tx_empty
);

    typedef enum logic [2:0] {
        S_CMD,
        S_DATA,
        S_EXEC,
        S_BURST,
        S_DRAIN
    } dec_state_t;

    dec_state_t state;
    dec_state_t state_nxt;

    frame_u frame;
    byte_t  regs [NUM_REGS];

    // Burst read walker
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [1:0]            burst_left;

    logic  emit;
    byte_t emit_value;
    logic  ans_valid;
    byte_t ans_value;

    ////////////////////
    // Next state and answer select

    always_comb
    begin
        state_nxt  = state;
        emit       = 1'b0;
        emit_value = frame.bytes.cmd + frame.bytes.data;
        case (state)
            S_CMD:
            begin
                if (rx_byte.valid)
                    state_nxt = S_DATA;
            end
            S_DATA:
            begin
                if (rx_byte.valid)
                    state_nxt = S_EXEC;
            end
            S_EXEC:
            begin
                state_nxt = S_DRAIN;
                emit      = 1'b1;
                case (frame.fields.op)
                    OP_WRITE:
                    begin
                        // Writes are silent
                        emit      = 1'b0;
                        state_nxt = S_CMD;
                    end
                    OP_READ:
                    begin
                        emit_value = regs[frame.fields.addr];
                        if (frame.fields.data[1:0] != 2'd0)
                            state_nxt = S_BURST;
                    end
                    default:
                    begin
                        if (frame.bytes.cmd == CMD_ECHO_CMD)
                            emit_value = CMD_ECHO_CMD;
                        else if (frame.bytes.cmd == CMD_ECHO_DATA)
                            emit_value = frame.bytes.data;
                    end
                endcase
            end
            S_BURST:
            begin
                emit       = 1'b1;
                emit_value = regs[rd_addr];
                if (burst_left == 2'd1)
                    state_nxt = S_DRAIN;
            end
            S_DRAIN:
            begin
                // Last strobe is not in the FIFO yet while it is still on the wire
                if (tx_empty && !ans_valid)
                    state_nxt = S_CMD;
            end
            default:
            begin
                state_nxt = S_CMD;
            end
        endcase
    end

    ////////////////////
    // Control and register bank

    always_ff @(posedge in_clk or posedge in_rst)
    begin
        if (in_rst)
        begin
            state      <= S_CMD;
            ready      <= 1'b0;
            ans_valid  <= 1'b0;
            rd_addr    <= '0;
            burst_left <= '0;
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else
        begin
            state     <= state_nxt;
            ready     <= (state_nxt == S_CMD) || (state_nxt == S_DATA);
            ans_valid <= emit;

            if (state == S_EXEC && frame.fields.op == OP_WRITE)
                regs[frame.fields.addr] <= frame.fields.data;

            // First read byte goes out from EXEC, the rest from BURST
            if (state == S_EXEC)
            begin
                rd_addr    <= frame.fields.addr + REG_ADDR_W'(1);
                burst_left <= frame.fields.data[1:0];
            end
            else if (state == S_BURST)
            begin
                rd_addr    <= rd_addr + REG_ADDR_W'(1);
                burst_left <= burst_left - 2'd1;
            end
        end
    end

    // Frame capture and answer byte
    always_ff @(posedge in_clk)
    begin
        if (rx_byte.valid && state == S_CMD)
            frame.bytes.cmd <= rx_byte.value;
        if (rx_byte.valid && state == S_DATA)
            frame.bytes.data <= rx_byte.value;
        ans_value <= emit_value;
    end

    assign ans_byte = '{valid: ans_valid, value: ans_value};

    assert property (@(posedge in_clk) disable iff (in_rst) rx_byte.valid |-> ready)
        else $error("byte arrived while decoder was busy");

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and judge the result from the simulation log

cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_comm_link -f verilog.f > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_comm_link > sim.log 2>&1
cat sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

// File: tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen
(
    output logic in_clk,
    output logic in_rst
);

    localparam time HALF_PERIOD = 50ns;

    // 100 ns free-running clock
    initial
    begin
        in_clk = 1'b0;
        forever #HALF_PERIOD in_clk = ~in_clk;
    end

    // Reset held through the first three rising edges
    initial
    begin
        in_rst = 1'b1;
        repeat (3) @(posedge in_clk);
        in_rst <= 1'b0;
    end

endmodule

// File: tb_comm_link.sv
`timescale 1ns/10ps

module tb_comm_link
    import comm_pkg::*;
();

    localparam int NUM_FRAMES = 300;
    localparam int TIMEOUT    = 200;

    logic  in_clk;
    logic  in_rst;
    byte_t rx_data;
    logic  rx_req;
    logic  rx_ack;
    logic  rx_enable;
    byte_t tx_data;
    logic  tx_req;
    logic  tx_ack;

    // Reference model
    byte_t model_regs [16];
    byte_t expected [$];
    int    received_total = 0;

    integer host_seed;
    integer ack_seed;

    // Previous values seen by the link monitor
    logic  prev_tx_req  = 1'b0;
    byte_t prev_tx_data = '0;
    logic  prev_rx_ack  = 1'b0;

    tb_clock_gen i_clk_gen (
        .in_clk (in_clk),
        .in_rst (in_rst)
    );

    comm_link_top i_dut (
        .in_clk    (in_clk),
        .in_rst    (in_rst),
        .rx_data   (rx_data),
        .rx_req    (rx_req),
        .rx_ack    (rx_ack),
        .rx_enable (rx_enable),
        .tx_data   (tx_data),
        .tx_req    (tx_req),
        .tx_ack    (tx_ack)
    );

    ////////////////////
    // Failure reporting

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping after the first failure");
    endtask

    task automatic report_wrong_value(input string what, input int got, input int exp);
        abort_run($sformatf("error at %0t ns: %s: got 0x%0h, expected 0x%0h",
                            $time, what, got, exp));
    endtask

    ////////////////////
    // Host side of the receive link

    task automatic wait_rx_enable();
        int cycles;
        cycles = 0;
        while (!rx_enable)
        begin
            @(posedge in_clk);
            cycles++;
            if (cycles > TIMEOUT)
                abort_run("timed out waiting for rx_enable to go high");
        end
    endtask

    task automatic wait_rx_ack(input logic level);
        int cycles;
        cycles = 0;
        while (rx_ack !== level)
        begin
            @(posedge in_clk);
            cycles++;
            if (cycles > TIMEOUT)
                abort_run($sformatf("timed out waiting for rx_ack to become %0b", level));
        end
    endtask

    // Offer a byte and hold req until the DUT acknowledges it
    task automatic start_byte(input byte_t value);
        wait_rx_enable();
        rx_data <= value;
        rx_req  <= 1'b1;
        wait_rx_ack(1'b1);
    endtask

    task automatic finish_byte();
        rx_req <= 1'b0;
        wait_rx_ack(1'b0);
    endtask

    task automatic push_expected(input byte_t value);
        expected.push_back(value);
    endtask

    // Answer rules, applied to the model registers
    task automatic predict_answer(input byte_t cmd, input byte_t data);
        int base;
        int count;
        base = int'(cmd[3:0]);
        if (cmd[7:4] == 4'h1)
            model_regs[base] = data;
        else if (cmd[7:4] == 4'h2)
        begin
            count = int'(data[1:0]) + 1;
            for (int k = 0; k < count; k++)
                push_expected(model_regs[(base + k) % 16]);
        end
        else if (cmd == 8'hAA)
            push_expected(8'hAA);
        else if (cmd == 8'h55)
            push_expected(data);
        else
            push_expected(byte_t'(cmd + data));
    endtask

    task automatic send_frame(input byte_t cmd, input byte_t data);
        start_byte(cmd);
        finish_byte();
        start_byte(data);
        // Answer counts as pending from this acknowledgement on
        predict_answer(cmd, data);
        finish_byte();
    endtask

    ////////////////////
    // Stimulus

    initial
    begin : stimulus
        byte_t cmd;
        byte_t data;
        int    kind;
        int    cycles;
        rx_data   = '0;
        rx_req    = 1'b0;
        host_seed = 32'h3505;
        for (int i = 0; i < 16; i++)
            model_regs[i] = '0;

        @(posedge in_clk);
        cycles = 0;
        while (in_rst)
        begin
            @(posedge in_clk);
            cycles++;
            if (cycles > TIMEOUT)
                abort_run("reset was never released");
        end
        assert (!rx_ack)
            else report_wrong_value("rx_ack after reset", int'(rx_ack), 0);
        assert (!tx_req)
            else report_wrong_value("tx_req after reset", int'(tx_req), 0);
        wait_rx_enable();

        for (int n = 0; n < NUM_FRAMES; n++)
        begin
            kind = int'({$random(host_seed)} % 10);
            cmd  = byte_t'($random(host_seed));
            data = byte_t'($random(host_seed));
            // Mix leans on register traffic
            case (kind)
                0, 1, 2: cmd = {OP_WRITE, cmd[3:0]};
                3, 4, 5: cmd = {OP_READ, cmd[3:0]};
                6:       cmd = CMD_ECHO_CMD;
                7:       cmd = CMD_ECHO_DATA;
                default: cmd = cmd;
            endcase
            send_frame(cmd, data);
        end

        // Last answer must drain and the link reopen
        cycles = 0;
        while (expected.size() != 0 || !rx_enable)
        begin
            @(posedge in_clk);
            cycles++;
            if (cycles > TIMEOUT)
                abort_run("answers did not drain after the last frame");
        end
        $display("frames sent: %0d, answer bytes checked: %0d", NUM_FRAMES, received_total);
        $display("TESTBENCH PASSED");
        $finish;
    end

    ////////////////////
    // Host side of the transmit link

    initial
    begin : responder
        int    delay;
        int    cycles;
        byte_t got;
        tx_ack   = 1'b0;
        ack_seed = 32'h3505;
        forever
        begin
            @(posedge in_clk);
            if (tx_req)
            begin
                delay = int'({$random(ack_seed)} % 6);
                repeat (delay) @(posedge in_clk);
                got = tx_data;
                assert (expected.size() != 0)
                    else abort_run("answer byte arrived when none was expected");
                assert (got == expected[0])
                    else report_wrong_value("answer byte", got, expected[0]);
                tx_ack <= 1'b1;
                cycles = 0;
                while (tx_req)
                begin
                    @(posedge in_clk);
                    cycles++;
                    if (cycles > TIMEOUT)
                        abort_run("timed out waiting for tx_req to drop after tx_ack");
                end
                // Random hold of ack after req has dropped
                delay = int'({$random(ack_seed)} % 6);
                repeat (delay) @(posedge in_clk);
                tx_ack <= 1'b0;
                // Byte is complete once ack goes back low
                void'(expected.pop_front());
                received_total++;
            end
        end
    end

    // Link rules, checked between edges
    always @(negedge in_clk)
    begin
        if (!in_rst)
        begin
            if (tx_req && !prev_tx_req)
            begin
                assert (!tx_ack)
                    else abort_run("tx_req rose while tx_ack was still high");
            end
            if (tx_req && prev_tx_req)
            begin
                assert (tx_data == prev_tx_data)
                    else report_wrong_value("tx_data during request", tx_data, prev_tx_data);
            end
            if (rx_ack && !prev_rx_ack)
            begin
                assert (expected.size() == 0)
                    else abort_run("a host byte was acknowledged while an answer was pending");
            end
            if (expected.size() != 0)
            begin
                assert (!rx_enable)
                    else abort_run("rx_enable went high while an answer was pending");
            end
        end
        prev_tx_req  = tx_req;
        prev_tx_data = tx_data;
        prev_rx_ack  = rx_ack;
    end

endmodule

// File: verilog.f
comm_pkg.sv
byte_rx_port.sv
proto_decoder.sv
byte_tx_port.sv
comm_link_top.sv
tb_clock_gen.sv
tb_comm_link.sv
